// ==== build.f ====
hdl/spi_boot_pkg.sv
hdl/spi_flash_reader.sv
hdl/boot_fifo.sv
hdl/uart_tx.sv
hdl/spi_boot_top.sv
test/spi_flash_model.sv
test/spi_boot_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module spi_boot_tb -f build.f -o spi_boot_sim

./obj_dir/spi_boot_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
grep -q "STATUS: PASS" sim.log

// ==== test/spi_boot_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_boot_tb import spi_boot_pkg::*; ();

	localparam int          CLK_PERIOD_NS = 20;
	localparam int          RESET_CYCLES  = 16;
	localparam logic [31:0] IMAGE_SEED    = 32'h9e1b949e;
	// Two full UART drains of the image plus margin
	localparam int WATCHDOG_NS = BOOT_LEN * 10 * UART_BIT_DIV * CLK_PERIOD_NS * 2 + 10_000;
	// SCK held low this long means the reader is waiting on credit
	localparam int STALL_CYCLES = 4 * SPI_HALF_DIV;

	logic        sys_clk_pad_i;
	logic        rst_n_i;
	logic        spi_miso_i;
	logic        spi_sck_o;
	logic        spi_mosi_o;
	logic        spi_cs_n_o;
	logic        uart_tx_o;
	logic        boot_done_o;
	byte_t       flash_cmd;
	flash_addr_t flash_addr;
	logic        flash_hdr_valid;

	byte_t rx_bytes [BOOT_LEN];
	int    rx_count       = 0;
	int    checked_count  = 0;
	int    error_count    = 0;
	int    sck_low_cycles = 0;
	logic  stall_seen     = 1'b0;
	time   last_stop_time = 0;

	initial begin
		sys_clk_pad_i = 1'b0;
		forever begin
			#(CLK_PERIOD_NS / 2) sys_clk_pad_i = ~sys_clk_pad_i;
		end
	end

	spi_boot_top spi_boot_top_inst (
		.sys_clk_pad_i (sys_clk_pad_i),
		.rst_n_i       (rst_n_i),
		.spi_miso_i    (spi_miso_i),
		.spi_sck_o     (spi_sck_o),
		.spi_mosi_o    (spi_mosi_o),
		.spi_cs_n_o    (spi_cs_n_o),
		.uart_tx_o     (uart_tx_o),
		.boot_done_o   (boot_done_o)
	);

	spi_flash_model #(.SEED(IMAGE_SEED)) spi_flash_model_inst (
		.spi_sck_i   (spi_sck_o),
		.spi_mosi_i  (spi_mosi_o),
		.spi_cs_n_i  (spi_cs_n_o),
		.spi_miso_o  (spi_miso_i),
		.cmd_o       (flash_cmd),
		.addr_o      (flash_addr),
		.hdr_valid_o (flash_hdr_valid)
	);

	//////////////////////////////////////////////////////////////////////////////
	// Reference and checking
	//////////////////////////////////////////////////////////////////////////////

	// Image byte N is the N-th random draw folded with its flash address
	function automatic byte_t expected_byte(input int index);
		integer      s;
		byte_t       value;
		flash_addr_t addr;
		s     = IMAGE_SEED;
		addr  = BOOT_ADDR + flash_addr_t'(index);
		value = '0;
		for (int i = 0; i <= int'(addr); i++) begin
			value = byte_t'($random(s));
		end
		return value ^ addr[7:0] ^ addr[15:8] ^ addr[23:16];
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// UART line decode, mid-bit sampling
	//////////////////////////////////////////////////////////////////////////////

	initial begin : uart_receive
		byte_t data;
		wait (rst_n_i === 1'b1);
		forever begin
			@(negedge sys_clk_pad_i);
			if (uart_tx_o === 1'b0) begin
				// Half a bit in, start must still be low
				repeat (UART_BIT_DIV / 2) @(negedge sys_clk_pad_i);
				check_value(uart_tx_o, 0, "start bit at mid bit");
				for (int i = 0; i < 8; i++) begin
					repeat (UART_BIT_DIV) @(negedge sys_clk_pad_i);
					data[i] = uart_tx_o;
				end
				repeat (UART_BIT_DIV) @(negedge sys_clk_pad_i);
				check_value(uart_tx_o, 1, $sformatf("stop bit of byte %0d", rx_count));
				last_stop_time = $time;
				if (rx_count < BOOT_LEN) begin
					rx_bytes[rx_count] = data;
				end
				rx_count++;
			end
		end
	end

	// In-order compare against the image
	initial begin : compare_bytes
		forever begin
			@(negedge sys_clk_pad_i);
			if (checked_count < rx_count) begin
				check_value(rx_count <= BOOT_LEN, 1, "no bytes beyond image length");
				check_value(rx_bytes[checked_count], expected_byte(checked_count),
					$sformatf("UART byte %0d", checked_count));
				checked_count++;
			end
		end
	end

	// Long SCK-low stretch with flash selected
	always @(negedge sys_clk_pad_i) begin
		if (spi_cs_n_o === 1'b0 && spi_sck_o === 1'b0) begin
			sck_low_cycles <= sck_low_cycles + 1;
			if (sck_low_cycles >= STALL_CYCLES) begin
				stall_seen <= 1'b1;
			end
		end else begin
			sck_low_cycles <= 0;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Boot did not complete within %0d ns", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////////////

	initial begin : main_sequence
		rst_n_i = 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge sys_clk_pad_i);
			check_value(spi_cs_n_o, 1, "chip select during reset");
			check_value(uart_tx_o, 1, "UART line during reset");
			check_value(boot_done_o, 0, "boot done during reset");
		end
		rst_n_i = 1'b1;
		// Nothing reaches the UART this early
		repeat (8) begin
			@(negedge sys_clk_pad_i);
			check_value(uart_tx_o, 1, "UART line after reset");
			check_value(boot_done_o, 0, "boot done after reset");
		end
		while (boot_done_o !== 1'b1) begin
			@(negedge sys_clk_pad_i);
		end
		check_value(rx_count, BOOT_LEN, "bytes received at boot done");
		check_value(($time - last_stop_time) >= (UART_BIT_DIV / 2) * CLK_PERIOD_NS, 1,
			"boot done after last stop bit");
		check_value(spi_cs_n_o, 1, "chip select at boot done");
		check_value(flash_hdr_valid, 1, "flash saw a full header");
		check_value(flash_cmd, FLASH_READ_CMD, "flash command");
		check_value(flash_addr, BOOT_ADDR, "flash start address");
		check_value(stall_seen, 1, "reader stalled on credit");
		// Line stays quiet for 20 bit times
		repeat (20 * UART_BIT_DIV) begin
			@(negedge sys_clk_pad_i);
			check_value(uart_tx_o, 1, "UART line idle after boot done");
			check_value(boot_done_o, 1, "boot done held");
		end
		check_value(rx_count, BOOT_LEN, "bytes received at end");
		check_value(checked_count, BOOT_LEN, "bytes compared at end");
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/spi_flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model import spi_boot_pkg::*; #(
	parameter logic [31:0] SEED      = 32'h0,
	parameter int          MEM_BYTES = 256
) (
	input  wire logic  spi_sck_i,
	input  wire logic  spi_mosi_i,
	input  wire logic  spi_cs_n_i,
	output logic       spi_miso_o,
	output byte_t      cmd_o,
	output flash_addr_t addr_o,
	output logic       hdr_valid_o
);

	byte_t                mem [MEM_BYTES];
	logic [SPI_HDR_W-1:0] hdr_shift = '0;
	int                   bit_cnt   = 0;
	logic                 miso      = 1'b0;
	logic                 hdr_seen  = 1'b0;
	byte_t                cmd_seen  = '0;
	flash_addr_t          addr_seen = '0;
	integer               seed;

	assign spi_miso_o  = miso;
	assign cmd_o       = cmd_seen;
	assign addr_o      = addr_seen;
	assign hdr_valid_o = hdr_seen;

	// Unmapped space reads as erased flash
	function automatic byte_t read_byte(input flash_addr_t addr);
		if (addr < flash_addr_t'(MEM_BYTES)) begin
			return mem[addr];
		end
		return 8'hff;
	endfunction

	// Random image, each byte also folded with its own address
	initial begin
		seed = SEED;
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem[i] = byte_t'($random(seed)) ^ byte_t'(i) ^ byte_t'(i >> 8) ^ byte_t'(i >> 16);
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Command and address decode on rising SCK
	//////////////////////////////////////////////////////////////////////////////

	always @(posedge spi_sck_i or posedge spi_cs_n_i) begin
		if (spi_cs_n_i) begin
			bit_cnt <= 0;
		end else begin
			if (bit_cnt < SPI_HDR_W) begin
				hdr_shift <= {hdr_shift[SPI_HDR_W-2:0], spi_mosi_i};
			end
			// Last address bit completes the header
			if (bit_cnt == SPI_HDR_W - 1) begin
				cmd_seen  <= hdr_shift[SPI_HDR_W-2:SPI_HDR_W-9];
				addr_seen <= {hdr_shift[$bits(flash_addr_t)-2:0], spi_mosi_i};
				hdr_seen  <= 1'b1;
			end
			bit_cnt <= bit_cnt + 1;
		end
	end

	// Data MSB first, next bit shown on falling SCK
	always @(negedge spi_sck_i) begin : drive_miso
		int    data_idx;
		byte_t cur;
		if (!spi_cs_n_i && bit_cnt >= SPI_HDR_W && cmd_seen == FLASH_READ_CMD) begin
			data_idx = bit_cnt - SPI_HDR_W;
			cur      = read_byte(addr_seen + flash_addr_t'(data_idx / 8));
			miso    <= cur[7 - (data_idx % 8)];
		end else begin
			miso <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/spi_boot_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_boot_top import spi_boot_pkg::*; (
	input  wire logic sys_clk_pad_i,
	input  wire logic rst_n_i,
	input  wire logic spi_miso_i,
	output logic      spi_sck_o,
	output logic      spi_mosi_o,
	output logic      spi_cs_n_o,
	output logic      uart_tx_o,
	output logic      boot_done_o
);

	logic  push;
	byte_t push_data;
	logic  credit;
	byte_t head;
	logic  fifo_empty;
	logic  pop;
	logic  uart_idle;
	logic  read_done;

	//////////////////////////////////////////////////////////////////////////////
	// Flash reader, FIFO, UART
	//////////////////////////////////////////////////////////////////////////////

	spi_flash_reader spi_flash_reader_inst (
		.clk_i       (sys_clk_pad_i),
		.rst_n_i     (rst_n_i),
		.spi_miso_i  (spi_miso_i),
		.credit_i    (credit),
		.spi_sck_o   (spi_sck_o),
		.spi_mosi_o  (spi_mosi_o),
		.spi_cs_n_o  (spi_cs_n_o),
		.push_o      (push),
		.read_done_o (read_done),
		.push_data_o (push_data)
	);

	// Credits only on the reader side
	boot_fifo boot_fifo_inst (
		.clk_i       (sys_clk_pad_i),
		.rst_n_i     (rst_n_i),
		.push_i      (push),
		.pop_i       (pop),
		.push_data_i (push_data),
		.head_o      (head),
		.empty_o     (fifo_empty),
		.credit_o    (credit)
	);

	uart_tx uart_tx_inst (
		.clk_i     (sys_clk_pad_i),
		.rst_n_i   (rst_n_i),
		.empty_i   (fifo_empty),
		.data_i    (head),
		.pop_o     (pop),
		.uart_tx_o (uart_tx_o),
		.idle_o    (uart_idle)
	);

	// Sticky once the image has fully drained onto the line
	always_ff @(posedge sys_clk_pad_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			boot_done_o <= 1'b0;
		end else if (read_done && fifo_empty && uart_idle) begin
			boot_done_o <= 1'b1;
		end
	end

	a_done_at_rest: assert property (@(posedge sys_clk_pad_i) disable iff (!rst_n_i)
		$rose(boot_done_o) |-> (spi_cs_n_o && uart_tx_o));

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx import spi_boot_pkg::*; (
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	input  wire logic  empty_i,
	input  wire byte_t data_i,
	output logic       pop_o,
	output logic       uart_tx_o,
	output logic       idle_o
);

	logic                  busy;
	logic [UART_DIV_W-1:0] bit_timer;
	logic [3:0]            bit_cnt;
	logic [8:0]            tx_shift;
	logic                  bit_end;

	//////////////////////////////////////////////////////////////////////////////
	// Pull from FIFO
	//////////////////////////////////////////////////////////////////////////////

	assign idle_o = !busy;
	// Take the head as soon as the line is free
	assign pop_o  = !busy && !empty_i;

	// Last cycle of the current bit
	assign bit_end = busy && (bit_timer == UART_DIV_W'(UART_BIT_DIV - 1));

	//////////////////////////////////////////////////////////////////////////////
	// 8N1 frame
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy      <= 1'b0;
			bit_timer <= '0;
			bit_cnt   <= '0;
			uart_tx_o <= 1'b1;
		end else if (pop_o) begin
			// Start bit
			busy      <= 1'b1;
			bit_timer <= '0;
			bit_cnt   <= '0;
			uart_tx_o <= 1'b0;
		end else if (busy) begin
			if (bit_end) begin
				bit_timer <= '0;
				// Bit 9 is the stop bit, line already high
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
				end else begin
					uart_tx_o <= tx_shift[0];
					bit_cnt   <= bit_cnt + 1'b1;
				end
			end else begin
				bit_timer <= bit_timer + 1'b1;
			end
		end
	end

	// Data LSB first, stop bit shifted in behind
	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			tx_shift <= {1'b1, data_i};
		end else if (bit_end) begin
			tx_shift <= {1'b1, tx_shift[8:1]};
		end
	end

	// Pop only on a filled FIFO, frame starts the next cycle
	a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pop_o |-> !empty_i ##1 (!uart_tx_o && !idle_o));

endmodule

`default_nettype wire

// ==== hdl/boot_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_fifo import spi_boot_pkg::*; (
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	input  wire logic  push_i,
	input  wire logic  pop_i,
	input  wire byte_t push_data_i,
	output byte_t      head_o,
	output logic       empty_o,
	output logic       credit_o
);

	byte_t                 mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic                  full;

	//////////////////////////////////////////////////////////////////////////////
	// Status and head
	//////////////////////////////////////////////////////////////////////////////

	assign empty_o = (count == '0);
	assign full    = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));

	// Head straight from storage, valid the cycle after a push
	assign head_o = mem[rd_ptr];

	// Storage
	always_ff @(posedge clk_i) begin
		if (push_i) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Pointers, occupancy and credit return
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			// Pointers wrap, depth is a power of two
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Freed slot goes back to the reader
			credit_o <= pop_i;
		end
	end

	a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		push_i |-> !full);

	a_no_pop_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== hdl/spi_flash_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader import spi_boot_pkg::*; (
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	input  wire logic  spi_miso_i,
	input  wire logic  credit_i,
	output logic       spi_sck_o,
	output logic       spi_mosi_o,
	output logic       spi_cs_n_o,
	output logic       push_o,
	output byte_t      push_data_o,
	output logic       read_done_o
);

	reader_state_t          state;
	logic [SPI_HDR_W-1:0]   tx_shift;
	byte_t                  rx_shift;
	logic [4:0]             bit_cnt;
	logic [SPI_DIV_W-1:0]   div_cnt;
	logic [BYTE_CNT_W-1:0]  byte_cnt;
	credit_t                credit_cnt;
	reader_state_t          data_next;
	logic                   shifting;
	logic                   half_tick;
	logic                   sck_rise;
	logic                   sck_fall;
	logic                   last_bit;

	//////////////////////////////////////////////////////////////////////////////
	// SPI clock timing
	//////////////////////////////////////////////////////////////////////////////

	// Divider only runs while bits are moving
	assign shifting  = (state == CMD) || (state == ADDR) || (state == DATA);
	assign half_tick = shifting && (div_cnt == SPI_DIV_W'(SPI_HALF_DIV - 1));
	assign sck_rise  = half_tick && !spi_sck_o;
	assign sck_fall  = half_tick && spi_sck_o;

	// Address phase is 24 bits, command and data bytes are 8
	assign last_bit = (bit_cnt == ((state == ADDR) ? 5'($bits(flash_addr_t) - 1) : 5'd7));

	// Header MSB first, zeros once it is all out
	assign spi_mosi_o = tx_shift[SPI_HDR_W-1];

	// Next data byte only starts with a credit in hand
	assign data_next = (credit_cnt == '0) ? WAIT_CREDIT : DATA;

	//////////////////////////////////////////////////////////////////////////////
	// Reader FSM
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state       <= IDLE;
			spi_cs_n_o  <= 1'b1;
			spi_sck_o   <= 1'b0;
			div_cnt     <= '0;
			bit_cnt     <= '0;
			tx_shift    <= '0;
			byte_cnt    <= '0;
			push_o      <= 1'b0;
			read_done_o <= 1'b0;
		end else begin
			push_o <= 1'b0;
			if (shifting) begin
				div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
			end
			if (half_tick) begin
				spi_sck_o <= !spi_sck_o;
			end
			case (state)
				IDLE: begin
					// Select flash and present first command bit
					state      <= CMD;
					spi_cs_n_o <= 1'b0;
					tx_shift   <= {FLASH_READ_CMD, BOOT_ADDR};
					bit_cnt    <= '0;
					div_cnt    <= '0;
				end
				CMD, ADDR: begin
					// MOSI moves on the falling edge
					if (sck_fall) begin
						tx_shift <= {tx_shift[SPI_HDR_W-2:0], 1'b0};
						if (last_bit) begin
							bit_cnt <= '0;
							state   <= (state == CMD) ? ADDR : data_next;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				DATA: begin
					// Eighth rising edge completes the byte
					if (sck_rise && last_bit) begin
						push_o   <= 1'b1;
						byte_cnt <= byte_cnt + 1'b1;
					end
					if (sck_fall) begin
						if (last_bit) begin
							bit_cnt <= '0;
							if (byte_cnt == BYTE_CNT_W'(BOOT_LEN)) begin
								state       <= DONE;
								spi_cs_n_o  <= 1'b1;
								read_done_o <= 1'b1;
							end else begin
								state <= data_next;
							end
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				WAIT_CREDIT: begin
					// SCK parked low, divider frozen
					if (credit_cnt != '0) begin
						state <= DATA;
					end
				end
				default: begin
					// Image copied, stay deselected
				end
			endcase
		end
	end

	// Receive shift, MSB first on rising SCK
	always_ff @(posedge clk_i) begin
		if (state == DATA && sck_rise) begin
			rx_shift <= {rx_shift[6:0], spi_miso_i};
			if (last_bit) begin
				push_data_o <= {rx_shift[6:0], spi_miso_i};
			end
		end
	end

	// One credit spent per push, one back per FIFO pop
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			credit_cnt <= credit_t'(FIFO_DEPTH);
		end else if (credit_i && !push_o) begin
			credit_cnt <= credit_cnt + 1'b1;
		end else if (push_o && !credit_i) begin
			credit_cnt <= credit_cnt - 1'b1;
		end
	end

	a_push_has_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		push_o |-> (credit_cnt != '0));

	a_cs_low_while_reading: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(state inside {CMD, ADDR, DATA, WAIT_CREDIT}) |-> !spi_cs_n_o);

endmodule

`default_nettype wire

// ==== hdl/spi_boot_pkg.sv ====
`default_nettype none

package spi_boot_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// Data types
	//////////////////////////////////////////////////////////////////////////////

	// One flash or UART data byte
	typedef logic [7:0]  byte_t;
	// Flash byte address
	typedef logic [23:0] flash_addr_t;
	// Reader credit count, 0 to FIFO_DEPTH
	typedef logic [3:0]  credit_t;

	//////////////////////////////////////////////////////////////////////////////
	// Boot copy constants
	//////////////////////////////////////////////////////////////////////////////

	localparam byte_t       FLASH_READ_CMD = 8'h03;
	localparam flash_addr_t BOOT_ADDR      = 24'h000000;
	localparam int          BOOT_LEN       = 64;
	localparam int          FIFO_DEPTH     = 8;
	// Clock cycles per SPI clock half period
	localparam int          SPI_HALF_DIV   = 2;
	// Clock cycles per UART bit, kept short for simulation
	localparam int          UART_BIT_DIV   = 16;

	// Derived widths
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int BYTE_CNT_W = $clog2(BOOT_LEN + 1);
	localparam int SPI_DIV_W  = $clog2(SPI_HALF_DIV + 1);
	localparam int UART_DIV_W = $clog2(UART_BIT_DIV + 1);
	// Command byte plus address, shifted out as one header
	localparam int SPI_HDR_W  = $bits(byte_t) + $bits(flash_addr_t);

	// Flash reader FSM
	typedef enum logic [2:0] {
		IDLE,
		CMD,
		ADDR,
		DATA,
		WAIT_CREDIT,
		DONE
	} reader_state_t;

endpackage

`default_nettype wire
